//--- iob_cache.f
rtl/iob_cache_pkg.sv
rtl/front_end.sv
rtl/cache_memory.sv
rtl/wtbuf_fifo.sv
rtl/back_end_native.sv
rtl/iob_cache.sv
sim/iob_cache_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := iob_cache_tb
FILELIST  := iob_cache.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a $fatal in the testbench makes the binary exit nonzero
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/iob_cache_tb.sv
module iob_cache_tb;

   // watchdog budget of about 300 requests at up to 60 cycles each
   localparam int OPS_BOUND     = 300;
   localparam int CYCLES_PER_OP = 60;
   localparam int MAX_CYCLES    = OPS_BOUND*CYCLES_PER_OP + 2000;
   localparam int MEM_WORDS     = 2**iob_cache_pkg::ADDR_W;

   logic                 clk;
   logic                 rst_n;
   logic                 valid;
   iob_cache_pkg::addr_t addr;
   iob_cache_pkg::data_t wdata;
   iob_cache_pkg::strb_t wstrb;
   iob_cache_pkg::data_t rdata;
   logic                 ready;
   logic                 mem_valid;
   iob_cache_pkg::addr_t mem_addr;
   iob_cache_pkg::data_t mem_wdata;
   iob_cache_pkg::strb_t mem_wstrb;
   iob_cache_pkg::data_t mem_rdata;
   logic                 mem_ready;

   iob_cache_pkg::data_t mem_array [MEM_WORDS];   // main memory model
   iob_cache_pkg::data_t shadow    [MEM_WORDS];   // expected contents
   iob_cache_pkg::addr_t exp_wr_addr[$];          // stores in issue order
   iob_cache_pkg::data_t exp_wr_data[$];
   iob_cache_pkg::strb_t exp_wr_strb[$];

   int                   seed      = 53861;       // stimulus draws
   int                   mem_seed  = 53861;       // memory latency draws
   bit                   slow_mem  = 1'b0;        // fixed worst-case latency
   bit                   mem_busy;
   int                   mem_wait;
   int                   mem_reads;               // reads served by memory
   int                   full_cycles = 0;
   int                   cycles      = 0;

   // request in flight for the compare process
   iob_cache_pkg::addr_t cur_addr;
   iob_cache_pkg::data_t cur_exp;
   bit                   cur_is_read = 1'b0;

   iob_cache u_iob_cache (
      .clk       (clk),
      .rst_n     (rst_n),
      .valid     (valid),
      .addr      (addr),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .rdata     (rdata),
      .ready     (ready),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   //////////////////////////////
   // reference model
   //////////////////////////////

   // every address gets its own word
   function automatic iob_cache_pkg::data_t init_word(input iob_cache_pkg::addr_t a);
      return {6'h2a, a, 6'h15, ~a};
   endfunction

   function automatic iob_cache_pkg::data_t merge_word(input iob_cache_pkg::data_t old_w,
                                                       input iob_cache_pkg::data_t new_w,
                                                       input iob_cache_pkg::strb_t s);
      iob_cache_pkg::data_t res;
      res = old_w;
      for (int b = 0; b < iob_cache_pkg::NBYTES; b++)
         if (s[b])
            res[b*8 +: 8] = new_w[b*8 +: 8];   // strobed byte only
      return res;
   endfunction

   function automatic iob_cache_pkg::data_t expected_rdata(input iob_cache_pkg::addr_t a);
      return shadow[a];
   endfunction

   function automatic iob_cache_pkg::addr_t make_addr(
      input iob_cache_pkg::tag_t                  t,
      input logic [iob_cache_pkg::LINE_OFF_W-1:0] idx,
      input iob_cache_pkg::word_off_t             w);
      return {t, idx, w};
   endfunction

   //////////////////////////////
   // checks
   //////////////////////////////

   task automatic fail_now(input string msg);
      $display("ERROR @ %0t: %s", $time, msg);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at the first failing check");
   endtask

   task automatic check_rdata(input iob_cache_pkg::addr_t a,
                              input iob_cache_pkg::data_t got,
                              input iob_cache_pkg::data_t exp);
      if (got !== exp)
         fail_now($sformatf("read 0x%0h returned 0x%08h, expected 0x%08h", a, got, exp));
   endtask

   task automatic check_mem_write(input iob_cache_pkg::addr_t a,
                                  input iob_cache_pkg::data_t d,
                                  input iob_cache_pkg::strb_t s);
      if (exp_wr_addr.size() == 0)
         fail_now($sformatf("memory write to 0x%0h with no store pending", a));
      else if (a !== exp_wr_addr[0] || d !== exp_wr_data[0] || s !== exp_wr_strb[0])
         fail_now($sformatf("memory write 0x%0h/0x%08h/%b, expected 0x%0h/0x%08h/%b",
                            a, d, s, exp_wr_addr[0], exp_wr_data[0], exp_wr_strb[0]));
      else
      begin
         void'(exp_wr_addr.pop_front());
         void'(exp_wr_data.pop_front());
         void'(exp_wr_strb.pop_front());
      end
   endtask

   task automatic check_reads(input int got, input int exp, input string what);
      if (got != exp)
         fail_now($sformatf("%s: %0d memory reads, expected %0d", what, got, exp));
   endtask

   // read data checked while ready is high
   always @(negedge clk)
   begin
      if (rst_n && ready && cur_is_read)
         check_rdata(cur_addr, rdata, cur_exp);
      if (u_iob_cache.full)
         full_cycles++;
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= MAX_CYCLES)
      begin
         $display("RESULT: FAIL");
         $fatal(1, "timeout, the cache stopped answering requests");
      end
   end

   //////////////////////////////
   // memory model
   //////////////////////////////

   initial
   begin
      mem_ready = 1'b0;
      mem_rdata = '0;
      mem_busy  = 1'b0;
      mem_wait  = 0;
      mem_reads = 0;
      for (int i = 0; i < MEM_WORDS; i++)
         mem_array[i] = init_word(iob_cache_pkg::addr_t'(i));
      forever
      begin
         @(negedge clk);
         if (!rst_n || mem_ready)
            mem_ready = 1'b0;   // one-cycle pulse
         else if (mem_valid)
         begin
            if (!mem_busy)
            begin
               mem_busy = 1'b1;
               mem_wait = slow_mem ? 3 : {$random(mem_seed)} % 4;
            end
            if (mem_wait != 0)
               mem_wait--;
            else
            begin
               mem_busy = 1'b0;
               if (mem_wstrb != '0)
               begin
                  check_mem_write(mem_addr, mem_wdata, mem_wstrb);
                  mem_array[mem_addr] = merge_word(mem_array[mem_addr], mem_wdata, mem_wstrb);
               end
               else
               begin
                  mem_rdata = mem_array[mem_addr];
                  mem_reads++;
               end
               mem_ready = 1'b1;
            end
         end
      end
   end

   //////////////////////////////
   // stimulus
   //////////////////////////////

   // holds the request until the ready pulse
   task automatic request(input iob_cache_pkg::addr_t a,
                          input iob_cache_pkg::data_t d,
                          input iob_cache_pkg::strb_t s);
      @(negedge clk);
      cur_addr    = a;
      cur_is_read = (s == '0);
      cur_exp     = expected_rdata(a);
      valid       = 1'b1;
      addr        = a;
      wdata       = d;
      wstrb       = s;
      do
         @(negedge clk);
      while (!ready);
      valid = 1'b0;
   endtask

   task automatic write_word(input iob_cache_pkg::addr_t a,
                             input iob_cache_pkg::data_t d,
                             input iob_cache_pkg::strb_t s);
      shadow[a] = merge_word(shadow[a], d, s);
      exp_wr_addr.push_back(a);
      exp_wr_data.push_back(d);
      exp_wr_strb.push_back(s);
      request(a, d, s);
   endtask

   task automatic read_word(input iob_cache_pkg::addr_t a);
      request(a, '0, '0);
   endtask

   initial
   begin
      int                   r0;
      iob_cache_pkg::addr_t ra;
      iob_cache_pkg::data_t rd;
      iob_cache_pkg::strb_t rs;

      rst_n = 1'b0;
      valid = 1'b0;
      addr  = '0;
      wdata = '0;
      wstrb = '0;
      for (int i = 0; i < MEM_WORDS; i++)
         shadow[i] = init_word(iob_cache_pkg::addr_t'(i));
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // cold read fills the line and the rest of it hits
      r0 = mem_reads;
      read_word(make_addr(4'd1, 4'd2, 2'd0));
      check_reads(mem_reads - r0, 4, "cold line fill");
      for (int w = 1; w < 4; w++)
         read_word(make_addr(4'd1, 4'd2, 2'(w)));
      check_reads(mem_reads - r0, 4, "reads in a filled line");

      // full and partial strobes
      write_word(make_addr(4'd3, 4'd5, 2'd1), 32'hdead_beef, 4'b1111);
      write_word(make_addr(4'd3, 4'd5, 2'd1), 32'h1122_3344, 4'b0101);
      write_word(make_addr(4'd3, 4'd5, 2'd1), 32'h99aa_bbcc, 4'b1000);
      read_word(make_addr(4'd3, 4'd5, 2'd1));
      write_word(make_addr(4'd3, 4'd5, 2'd1), 32'h0f0f_0f0f, 4'b0010);   // now a hit
      read_word(make_addr(4'd3, 4'd5, 2'd1));

      // write hit merges without a memory read
      r0 = mem_reads;
      write_word(make_addr(4'd1, 4'd2, 2'd3), 32'hcafe_f00d, 4'b0110);
      read_word(make_addr(4'd1, 4'd2, 2'd3));
      check_reads(mem_reads - r0, 0, "read after write hit");
      // write miss leaves the line alone
      write_word(make_addr(4'd2, 4'd7, 2'd0), 32'h5566_7788, 4'b1111);
      r0 = mem_reads;
      read_word(make_addr(4'd2, 4'd7, 2'd0));
      check_reads(mem_reads - r0, 4, "read after write miss");

      // tags 5 and 6 on one index evict each other
      for (int n = 0; n < 2; n++)
      begin
         r0 = mem_reads;
         read_word(make_addr(4'd5, 4'd9, 2'd2));
         read_word(make_addr(4'd6, 4'd9, 2'd2));
         write_word(make_addr(4'd5, 4'd9, 2'd2), 32'h0bad_0000 + n, 4'b1111);
         read_word(make_addr(4'd5, 4'd9, 2'd2));
         // line holds tag 5 after the first pass so its opening read hits
         check_reads(mem_reads - r0, (n == 0) ? 12 : 8, "conflicting tags");
      end

      // store burst against slow memory
      slow_mem    = 1'b1;
      full_cycles = 0;
      for (int i = 0; i < 12; i++)
         write_word(make_addr(4'd4, 4'(11 + i/4), 2'(i%4)), 32'ha5a5_0000 + i, 4'b1111);
      read_word(make_addr(4'd4, 4'd13, 2'd2));   // miss right after the burst
      if (full_cycles == 0)
         fail_now("the write buffer never filled during the store burst");
      slow_mem = 1'b0;

      // random mix over four tags
      for (int i = 0; i < 200; i++)
      begin
         ra = iob_cache_pkg::addr_t'({$random(seed)} % 256);
         rd = $random(seed);
         rs = iob_cache_pkg::strb_t'($random(seed));
         if ($random(seed) & 1)
            read_word(ra);
         else
            write_word(ra, rd, (rs == '0) ? 4'b1111 : rs);
      end

      // every store must reach memory
      while (exp_wr_addr.size() != 0)
         @(negedge clk);

      $display("RESULT: PASS");
      $finish;
   end

endmodule

//--- rtl/iob_cache.sv
module iob_cache (
   input  logic                 clk,
   input  logic                 rst_n,
   // processor port
   input  logic                 valid,
   input  iob_cache_pkg::addr_t addr,
   input  iob_cache_pkg::data_t wdata,
   input  iob_cache_pkg::strb_t wstrb,
   output iob_cache_pkg::data_t rdata,
   output logic                 ready,
   // memory port
   output logic                 mem_valid,
   output iob_cache_pkg::addr_t mem_addr,
   output iob_cache_pkg::data_t mem_wdata,
   output iob_cache_pkg::strb_t mem_wstrb,
   input  iob_cache_pkg::data_t mem_rdata,
   input  logic                 mem_ready
);

   // front end to cache memory
   logic                      data_valid, data_ready;
   iob_cache_pkg::addr_t      data_addr;
   iob_cache_pkg::data_t      data_wdata, data_rdata;
   iob_cache_pkg::strb_t      data_wstrb;

   // buffer in and out
   logic                      push, pop, full, empty;
   iob_cache_pkg::addr_t      push_addr, head_addr;
   iob_cache_pkg::data_t      push_wdata, head_wdata;
   iob_cache_pkg::strb_t      push_wstrb, head_wstrb;

   // line fill
   logic                      replace_valid, replace_ready, read_valid;
   iob_cache_pkg::line_addr_t replace_addr;
   iob_cache_pkg::word_off_t  read_addr;
   iob_cache_pkg::data_t      read_rdata;

   front_end u_front_end (
      .clk        (clk),        .rst_n      (rst_n),
      .valid      (valid),      .addr       (addr),
      .wdata      (wdata),      .wstrb      (wstrb),
      .rdata      (rdata),      .ready      (ready),
      .data_valid (data_valid), .data_addr  (data_addr),
      .data_wdata (data_wdata), .data_wstrb (data_wstrb),
      .data_rdata (data_rdata), .data_ready (data_ready)
   );

   cache_memory u_cache_memory (
      .clk           (clk),           .rst_n         (rst_n),
      .data_valid    (data_valid),    .data_addr     (data_addr),
      .data_wdata    (data_wdata),    .data_wstrb    (data_wstrb),
      .data_rdata    (data_rdata),    .data_ready    (data_ready),
      .push          (push),          .push_addr     (push_addr),
      .push_wdata    (push_wdata),    .push_wstrb    (push_wstrb),
      .full          (full),          .empty         (empty),
      .replace_valid (replace_valid), .replace_addr  (replace_addr),
      .replace_ready (replace_ready), .read_valid    (read_valid),
      .read_addr     (read_addr),     .read_rdata    (read_rdata)
   );

   wtbuf_fifo u_wtbuf_fifo (
      .clk        (clk),        .rst_n      (rst_n),
      .push       (push),       .push_addr  (push_addr),
      .push_wdata (push_wdata), .push_wstrb (push_wstrb),
      .pop        (pop),        .head_addr  (head_addr),
      .head_wdata (head_wdata), .head_wstrb (head_wstrb),
      .full       (full),       .empty      (empty)
   );

   back_end_native u_back_end (
      .clk           (clk),           .rst_n         (rst_n),
      .empty         (empty),         .head_addr     (head_addr),
      .head_wdata    (head_wdata),    .head_wstrb    (head_wstrb),
      .pop           (pop),
      .replace_valid (replace_valid), .replace_addr  (replace_addr),
      .replace_ready (replace_ready), .read_valid    (read_valid),
      .read_addr     (read_addr),     .read_rdata    (read_rdata),
      .mem_valid     (mem_valid),     .mem_addr      (mem_addr),
      .mem_wdata     (mem_wdata),     .mem_wstrb     (mem_wstrb),
      .mem_rdata     (mem_rdata),     .mem_ready     (mem_ready)
   );

endmodule

//--- rtl/back_end_native.sv
module back_end_native (
   input  logic                      clk,
   input  logic                      rst_n,
   // write-through buffer head
   input  logic                      empty,
   input  iob_cache_pkg::addr_t      head_addr,
   input  iob_cache_pkg::data_t      head_wdata,
   input  iob_cache_pkg::strb_t      head_wstrb,
   output logic                      pop,
   // line fill
   input  logic                      replace_valid,
   input  iob_cache_pkg::line_addr_t replace_addr,
   output logic                      replace_ready,
   output logic                      read_valid,
   output iob_cache_pkg::word_off_t  read_addr,
   output iob_cache_pkg::data_t      read_rdata,
   // native memory port
   output logic                      mem_valid,
   output iob_cache_pkg::addr_t      mem_addr,
   output iob_cache_pkg::data_t      mem_wdata,
   output iob_cache_pkg::strb_t      mem_wstrb,
   input  iob_cache_pkg::data_t      mem_rdata,
   input  logic                      mem_ready
);

   typedef enum logic [1:0] {S_IDLE, S_WRITE, S_FILL} state_t;

   state_t                   state;
   iob_cache_pkg::word_off_t word_cnt;   // fill word index
   logic                     last_word;

   assign last_word = &word_cnt;

   assign pop           = (state == S_WRITE) & mem_ready;   // head written
   assign read_valid    = (state == S_FILL) & mem_ready;
   assign read_addr     = word_cnt;
   assign read_rdata    = mem_rdata;
   assign replace_ready = read_valid & last_word;

   // request held steady by state and buffer head until mem_ready
   always_comb
   begin
      mem_valid = (state != S_IDLE);
      mem_addr  = head_addr;
      mem_wdata = head_wdata;
      mem_wstrb = head_wstrb;
      if (state == S_FILL)
      begin
         mem_addr  = {replace_addr, word_cnt};
         mem_wdata = '0;
         mem_wstrb = '0;   // read
      end
   end

   //////////////////////////////
   // memory port FSM
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state    <= S_IDLE;
         word_cnt <= '0;
      end
      else
      begin
         case (state)
            S_IDLE:
            begin
               if (!empty)
                  state <= S_WRITE;   // stores first
               else if (replace_valid)
               begin
                  word_cnt <= '0;
                  state    <= S_FILL;
               end
            end
            S_WRITE:
            begin
               if (mem_ready)
                  state <= S_IDLE;
            end
            S_FILL:
            begin
               if (mem_ready)
               begin
                  word_cnt <= word_cnt + 1'b1;
                  if (last_word)
                     state <= S_IDLE;   // line complete
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

//--- rtl/wtbuf_fifo.sv
module wtbuf_fifo (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 push,
   input  iob_cache_pkg::addr_t push_addr,
   input  iob_cache_pkg::data_t push_wdata,
   input  iob_cache_pkg::strb_t push_wstrb,
   input  logic                 pop,
   output iob_cache_pkg::addr_t head_addr,
   output iob_cache_pkg::data_t head_wdata,
   output iob_cache_pkg::strb_t head_wstrb,
   output logic                 full,
   output logic                 empty
);

   iob_cache_pkg::addr_t                    addr_mem  [2**iob_cache_pkg::WTBUF_DEPTH_W];
   iob_cache_pkg::data_t                    wdata_mem [2**iob_cache_pkg::WTBUF_DEPTH_W];
   iob_cache_pkg::strb_t                    wstrb_mem [2**iob_cache_pkg::WTBUF_DEPTH_W];
   logic [iob_cache_pkg::WTBUF_DEPTH_W-1:0] wr_ptr;
   logic [iob_cache_pkg::WTBUF_DEPTH_W-1:0] rd_ptr;
   logic [iob_cache_pkg::WTBUF_DEPTH_W:0]   count;   // one extra bit for full
   logic                                    do_push;
   logic                                    do_pop;

   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   assign full  = count[iob_cache_pkg::WTBUF_DEPTH_W];   // msb set only at depth
   assign empty = (count == '0);

   // pointers and level
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;   // wraps
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (do_push & ~do_pop)
            count <= count + 1'b1;
         else if (do_pop & ~do_push)
            count <= count - 1'b1;     // push and pop together keep the level
      end
   end

   // storage
   always_ff @(posedge clk)
   begin
      if (do_push)
      begin
         addr_mem[wr_ptr]  <= push_addr;
         wdata_mem[wr_ptr] <= push_wdata;
         wstrb_mem[wr_ptr] <= push_wstrb;
      end
   end

   // oldest entry, meaningful when not empty
   assign head_addr  = addr_mem[rd_ptr];
   assign head_wdata = wdata_mem[rd_ptr];
   assign head_wstrb = wstrb_mem[rd_ptr];

endmodule

//--- rtl/cache_memory.sv
module cache_memory (
   input  logic                      clk,
   input  logic                      rst_n,
   // registered request from front end
   input  logic                      data_valid,
   input  iob_cache_pkg::addr_t      data_addr,
   input  iob_cache_pkg::data_t      data_wdata,
   input  iob_cache_pkg::strb_t      data_wstrb,
   output iob_cache_pkg::data_t      data_rdata,
   output logic                      data_ready,
   // write-through buffer
   output logic                      push,
   output iob_cache_pkg::addr_t      push_addr,
   output iob_cache_pkg::data_t      push_wdata,
   output iob_cache_pkg::strb_t      push_wstrb,
   input  logic                      full,
   input  logic                      empty,
   // line fill from back end
   output logic                      replace_valid,
   output iob_cache_pkg::line_addr_t replace_addr,
   input  logic                      replace_ready,
   input  logic                      read_valid,
   input  iob_cache_pkg::word_off_t  read_addr,
   input  iob_cache_pkg::data_t      read_rdata
);

   typedef enum logic [1:0] {S_IDLE, S_MISS, S_FILL} state_t;

   state_t                                   state;
   iob_cache_pkg::tag_t                      tag_mem  [2**iob_cache_pkg::LINE_OFF_W];
   iob_cache_pkg::data_t                     data_mem [2**(iob_cache_pkg::LINE_OFF_W +
                                                           iob_cache_pkg::WORD_OFF_W)];
   logic [2**iob_cache_pkg::LINE_OFF_W-1:0]  line_vld;   // one valid bit per line

   iob_cache_pkg::tag_t                      tag;
   logic [iob_cache_pkg::LINE_OFF_W-1:0]     index;
   iob_cache_pkg::word_off_t                 woff;
   logic                                     hit;
   logic                                     is_write;
   logic                                     req;

   assign {tag, index, woff} = data_addr;
   assign hit      = line_vld[index] & (tag_mem[index] == tag);
   assign is_write = |data_wstrb;
   // new request, ignored in its own ready cycle
   assign req      = data_valid & ~data_ready & (state == S_IDLE);

   // every store goes through the buffer, hit or miss
   assign push       = req & is_write & ~full;   // full stalls the write
   assign push_addr  = data_addr;
   assign push_wdata = data_wdata;
   assign push_wstrb = data_wstrb;

   assign replace_addr = data_addr[iob_cache_pkg::ADDR_W-1:iob_cache_pkg::WORD_OFF_W];

   //////////////////////////////
   // control
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state         <= S_IDLE;
         data_ready    <= 1'b0;
         replace_valid <= 1'b0;
         line_vld      <= '0;
      end
      else
      begin
         data_ready <= 1'b0;   // pulse
         case (state)
            S_IDLE:
            begin
               if (push)
                  data_ready <= 1'b1;   // write acked once queued
               else if (req & ~is_write & hit)
                  data_ready <= 1'b1;
               else if (req & ~is_write)
                  state <= S_MISS;
            end
            S_MISS:
            begin
               // drain pending stores first, memory must not be stale
               if (empty)
               begin
                  replace_valid <= 1'b1;
                  state         <= S_FILL;
               end
            end
            S_FILL:
            begin
               if (replace_ready)   // comes with the last word
               begin
                  replace_valid   <= 1'b0;
                  line_vld[index] <= 1'b1;
                  data_ready      <= 1'b1;
                  state           <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   //////////////////////////////
   // arrays and read data
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (push & hit)   // write hit, merge strobed bytes
      begin
         for (int b = 0; b < iob_cache_pkg::NBYTES; b++)
            if (data_wstrb[b])
               data_mem[{index, woff}][b*8 +: 8] <= data_wdata[b*8 +: 8];
      end
      if (req & ~is_write & hit)
         data_rdata <= data_mem[{index, woff}];
      if (read_valid)   // fill word
      begin
         data_mem[{index, read_addr}] <= read_rdata;
         if (read_addr == woff)
            data_rdata <= read_rdata;   // keep the requested word
      end
      if (replace_ready)
         tag_mem[index] <= tag;
   end

endmodule

//--- rtl/front_end.sv
module front_end (
   input  logic                 clk,
   input  logic                 rst_n,
   // processor side
   input  logic                 valid,
   input  iob_cache_pkg::addr_t addr,
   input  iob_cache_pkg::data_t wdata,
   input  iob_cache_pkg::strb_t wstrb,
   output iob_cache_pkg::data_t rdata,
   output logic                 ready,
   // towards cache memory
   output logic                 data_valid,
   output iob_cache_pkg::addr_t data_addr,
   output iob_cache_pkg::data_t data_wdata,
   output iob_cache_pkg::strb_t data_wstrb,
   input  iob_cache_pkg::data_t data_rdata,
   input  logic                 data_ready
);

   logic capture;

   // only when no request is held
   // data_valid is still high in the ready cycle so a held valid is ignored
   assign capture = valid & ~data_valid;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         data_valid <= 1'b0;
      end
      else if (data_ready)
      begin
         data_valid <= 1'b0;   // request done
      end
      else if (capture)
      begin
         data_valid <= 1'b1;
      end
   end

   // request payload
   always_ff @(posedge clk)
   begin
      if (capture)
      begin
         data_addr  <= addr;
         data_wdata <= wdata;
         data_wstrb <= wstrb;   // zero strobes mean read
      end
   end

   assign rdata = data_rdata;   // valid with ready only
   assign ready = data_ready;   // one-cycle pulse from cache memory

endmodule

//--- rtl/iob_cache_pkg.sv
package iob_cache_pkg;

   //////////////////////////////
   // cache geometry
   //////////////////////////////

   localparam int ADDR_W        = 10;         // word address, byte bits dropped
   localparam int DATA_W        = 32;         // front and back end share it
   localparam int NBYTES        = DATA_W/8;   // strobe bits per word

   // address split, msb to lsb: tag | index | word offset
   localparam int LINE_OFF_W    = 4;          // 16 lines
   localparam int WORD_OFF_W    = 2;          // 4 words per line
   localparam int TAG_W         = ADDR_W - LINE_OFF_W - WORD_OFF_W;

   localparam int WTBUF_DEPTH_W = 2;          // 4 queued stores

   //////////////////////////////
   // shared types
   //////////////////////////////

   typedef logic [ADDR_W-1:0]            addr_t;
   typedef logic [DATA_W-1:0]            data_t;
   typedef logic [NBYTES-1:0]            strb_t;
   typedef logic [TAG_W-1:0]             tag_t;
   typedef logic [ADDR_W-WORD_OFF_W-1:0] line_addr_t;   // tag and index only
   typedef logic [WORD_OFF_W-1:0]        word_off_t;

endpackage
